// ==== Makefile ====
VERILATOR ?= verilator
TOP       := processor_tb
FILELIST  := vlog.f
FLAGS     := --timing --assert
BUILD_DIR := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== src/decode_lane.sv ====
`timescale 1ns/1ps

module decode_lane (
  fetch_if.sink  fetch,
  uop_if.source  uop
);
  import isa_pkg::*;
  import pipe_pkg::*;

  opcode_e opcode;

  assign opcode = opcode_e'(fetch.instr[OPCODE_MSB:OPCODE_LSB]);

  // purely combinational, handshake passes straight through
  assign uop.valid   = fetch.valid;
  assign fetch.ready = uop.ready;

  // register fields
  assign uop.rd  = fetch.instr[RD_MSB:RD_LSB];
  assign uop.rs  = fetch.instr[RS_MSB:RS_LSB];
  assign uop.rt  = fetch.instr[RT_MSB:RT_LSB];
  // raw immediate, execute sign-extends it
  assign uop.imm = fetch.instr[IMM_MSB:IMM_LSB];

  always_comb begin
    uop.alu_op  = ALU_ADD;
    uop.use_imm = 1'b0;
    uop.halt    = 1'b0;
    case (opcode)
      OP_ADD:  uop.alu_op = ALU_ADD;
      OP_SUB:  uop.alu_op = ALU_SUB;
      OP_AND:  uop.alu_op = ALU_AND;
      OP_OR:   uop.alu_op = ALU_OR;
      OP_XOR:  uop.alu_op = ALU_XOR;
      OP_SLT:  uop.alu_op = ALU_SLT;
      OP_ADDI: begin
        uop.alu_op  = ALU_ADD;
        uop.use_imm = 1'b1;
      end
      // unknown opcode stops the machine
      default: uop.halt = 1'b1;
    endcase
  end

endmodule

// ==== src/fetch_if.sv ====
`timescale 1ns/1ps

interface fetch_if;
  import isa_pkg::*;

  logic   valid;
  instr_t instr;
  logic   ready;

  modport source (
    output valid, instr,
    input  ready
  );
  modport sink (
    input  valid, instr,
    output ready
  );
endinterface

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                prog_valid,
  output logic                prog_ready,
  input  pipe_pkg::imem_addr_t prog_addr,
  input  isa_pkg::instr_t     prog_data,
  input  logic                start,
  input  logic                halted,
  fetch_if.source             lanes [pipe_pkg::NUM_LANES]
);
  import isa_pkg::*;
  import pipe_pkg::*;

  exec_state_e          state;
  pair_addr_t           pair_cnt;
  instr_t               bank [NUM_LANES][PAIR_DEPTH];
  instr_t               fetch_instr [NUM_LANES];
  logic [NUM_LANES-1:0] fetch_valid;
  logic                 lane_ready [NUM_LANES];
  logic                 any_busy;
  logic                 load_pair;

  ////////////////////
  // program load, low address bits pick the bank
  always_ff @(posedge clk) begin
    if (prog_valid && prog_ready) begin
      bank[prog_addr[LANE_SEL_W-1:0]][prog_addr[IMEM_AW-1:LANE_SEL_W]] <= prog_data;
    end
  end

  assign prog_ready = (state == ST_IDLE);

  ////////////////////
  // a lane is busy if it still holds an instruction after this edge
  always_comb begin
    any_busy = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      any_busy = any_busy | (fetch_valid[i] & ~lane_ready[i]);
    end
  end

  assign load_pair = (state == ST_RUN) && !halted && !any_busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      pair_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: if (start) begin
          state    <= ST_RUN;
          pair_cnt <= '0;
        end
        ST_RUN: begin
          if (halted) state <= ST_HALTED;
          else if (load_pair) pair_cnt <= pair_cnt + 1'b1;
        end
        default: ;
      endcase
    end
  end

  // per-lane valid clears on that lane's own transfer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_valid <= '0;
    end else if (load_pair) begin
      fetch_valid <= '1;
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (lane_ready[i]) fetch_valid[i] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_pair) begin
      for (int i = 0; i < NUM_LANES; i++) fetch_instr[i] <= bank[i][pair_cnt];
    end
  end

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    assign lanes[i].valid = fetch_valid[i];
    assign lanes[i].instr = fetch_instr[i];
    assign lane_ready[i]  = lanes[i].ready;
  end

endmodule

// ==== src/isa_pkg.sv ====
package isa_pkg;

  // machine sizes
  localparam int INSTR_W  = 16;
  localparam int DATA_W   = 16;
  localparam int NUM_REGS = 8;
  localparam int REG_AW   = $clog2(NUM_REGS);
  localparam int OPCODE_W = 4;
  localparam int IMM_W    = 6;

  // instruction field positions
  localparam int OPCODE_MSB = 15;
  localparam int OPCODE_LSB = 12;
  localparam int RD_MSB     = 11;
  localparam int RD_LSB     = 9;
  localparam int RS_MSB     = 8;
  localparam int RS_LSB     = 6;
  localparam int RT_MSB     = 5;
  localparam int RT_LSB     = 3;
  localparam int IMM_MSB    = 5;
  localparam int IMM_LSB    = 0;

  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [REG_AW-1:0]  reg_addr_t;
  typedef logic [INSTR_W-1:0] instr_t;
  typedef logic [IMM_W-1:0]   imm_t;

  // any encoding not listed here decodes as halt
  typedef enum logic [OPCODE_W-1:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLT  = 4'd5,
    OP_ADDI = 4'd6
  } opcode_e;

endpackage

// ==== src/issue_execute.sv ====
`timescale 1ns/1ps

module issue_execute (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           retire_ready,
  uop_if.sink                            lanes [pipe_pkg::NUM_LANES],
  output logic [pipe_pkg::NUM_LANES-1:0] retire_valid,
  output isa_pkg::reg_addr_t             retire_rd_0,
  output isa_pkg::data_t                 retire_data_0,
  output isa_pkg::reg_addr_t             retire_rd_1,
  output isa_pkg::data_t                 retire_data_1,
  output logic                           halted,
  output logic                           done
);
  import isa_pkg::*;
  import pipe_pkg::*;

  exec_state_e state;
  data_t       regs [NUM_REGS];

  // per-lane copies of the micro-ops
  logic      u_valid   [NUM_LANES];
  logic      u_halt    [NUM_LANES];
  logic      u_use_imm [NUM_LANES];
  alu_op_e   u_op      [NUM_LANES];
  reg_addr_t u_rd      [NUM_LANES];
  reg_addr_t u_rs      [NUM_LANES];
  reg_addr_t u_rt      [NUM_LANES];
  imm_t      u_imm     [NUM_LANES];
  data_t     src_a     [NUM_LANES];
  data_t     src_b     [NUM_LANES];
  data_t     result    [NUM_LANES];
  logic      lane_ready [NUM_LANES];
  logic      fire      [NUM_LANES];

  reg_addr_t rd_q   [NUM_LANES];
  data_t     data_q [NUM_LANES];

  logic advance, go, dep, lane0_clear, halt_now;

  function automatic data_t alu_calc(alu_op_e op, data_t a, data_t b);
    case (op)
      ALU_ADD: alu_calc = a + b;
      ALU_SUB: alu_calc = a - b;
      ALU_AND: alu_calc = a & b;
      ALU_OR:  alu_calc = a | b;
      ALU_XOR: alu_calc = a ^ b;
      ALU_SLT: alu_calc = ($signed(a) < $signed(b)) ? data_t'(1) : '0;
      default: alu_calc = '0;
    endcase
  endfunction

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    assign u_valid[i]     = lanes[i].valid;
    assign u_halt[i]      = lanes[i].halt;
    assign u_use_imm[i]   = lanes[i].use_imm;
    assign u_op[i]        = lanes[i].alu_op;
    assign u_rd[i]        = lanes[i].rd;
    assign u_rs[i]        = lanes[i].rs;
    assign u_rt[i]        = lanes[i].rt;
    assign u_imm[i]       = lanes[i].imm;
    assign lanes[i].ready = lane_ready[i];
    // r0 reads zero
    assign src_a[i]  = (u_rs[i] == '0) ? '0 : regs[u_rs[i]];
    assign src_b[i]  = u_use_imm[i] ? data_t'($signed(u_imm[i])) :
                       (u_rt[i] == '0) ? '0 : regs[u_rt[i]];
    assign result[i] = alu_calc(u_op[i], src_a[i], src_b[i]);
  end

  ////////////////////
  // issue control
  assign advance = !(|retire_valid) || retire_ready;
  assign go      = (state != ST_HALTED) && advance;

  // lane 1 reads what lane 0 writes
  assign dep = u_valid[0] && (u_rd[0] != '0) &&
               ((u_rs[1] == u_rd[0]) || (!u_use_imm[1] && (u_rt[1] == u_rd[0])));

  assign fire[0]       = go && u_valid[0] && !u_halt[0];
  assign lane0_clear   = !u_valid[0] || fire[0];
  assign lane_ready[0] = go;
  assign lane_ready[1] = go && lane0_clear && !dep;
  assign fire[1]       = lane_ready[1] && u_valid[1] && !u_halt[1];
  assign halt_now      = (go && u_valid[0] && u_halt[0]) ||
                         (lane_ready[1] && u_valid[1] && u_halt[1]);

  ////////////////////
  // register file, lane 1 is younger and wins a shared rd
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_REGS; r++) regs[r] <= '0;
    end else begin
      if (fire[0] && (u_rd[0] != '0)) regs[u_rd[0]] <= result[0];
      if (fire[1] && (u_rd[1] != '0)) regs[u_rd[1]] <= result[1];
    end
  end

  // a lone lane 1 is the oldest, so it retires in slot 0
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retire_valid <= '0;
    end else if (advance) begin
      retire_valid <= {fire[0] && fire[1], fire[0] || fire[1]};
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      rd_q[0]   <= fire[0] ? u_rd[0] : u_rd[1];
      data_q[0] <= fire[0] ? result[0] : result[1];
      rd_q[1]   <= u_rd[1];
      data_q[1] <= result[1];
    end
  end

  assign retire_rd_0   = rd_q[0];
  assign retire_data_0 = data_q[0];
  assign retire_rd_1   = rd_q[1];
  assign retire_data_1 = data_q[1];

  ////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (halt_now) state <= ST_HALTED;
          else if (fire[0] || fire[1]) state <= ST_RUN;
        end
        ST_RUN: if (halt_now) state <= ST_HALTED;
        default: ;
      endcase
    end
  end

  assign halted = (state == ST_HALTED);
  // nothing enters the retire register once halted
  assign done   = halted && !(|retire_valid);

endmodule

// ==== src/pipe_pkg.sv ====
package pipe_pkg;

  localparam int NUM_LANES  = 2;
  localparam int LANE_SEL_W = $clog2(NUM_LANES);
  localparam int IMEM_DEPTH = 32;
  localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
  localparam int PAIR_DEPTH = IMEM_DEPTH / NUM_LANES;
  localparam int PAIR_AW    = $clog2(PAIR_DEPTH);

  typedef logic [IMEM_AW-1:0] imem_addr_t;
  typedef logic [PAIR_AW-1:0] pair_addr_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
  } alu_op_e;

  // shared by fetch and execute
  typedef enum logic [1:0] {
    ST_IDLE, ST_RUN, ST_HALTED
  } exec_state_e;

endpackage

// ==== src/processor.sv ====
`timescale 1ns/1ps

module processor (
  input  logic                           clk,
  input  logic                           rst_n,
  // program load
  input  logic                           prog_valid,
  output logic                           prog_ready,
  input  pipe_pkg::imem_addr_t           prog_addr,
  input  isa_pkg::instr_t                prog_data,
  input  logic                           start,
  // retire
  output logic [pipe_pkg::NUM_LANES-1:0] retire_valid,
  input  logic                           retire_ready,
  output isa_pkg::reg_addr_t             retire_rd_0,
  output isa_pkg::data_t                 retire_data_0,
  output isa_pkg::reg_addr_t             retire_rd_1,
  output isa_pkg::data_t                 retire_data_1,
  output logic                           done
);
  import pipe_pkg::*;

  logic halted;

  fetch_if fetch_bus [NUM_LANES] ();
  uop_if   uop_bus   [NUM_LANES] ();

  fetch_unit u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .prog_valid (prog_valid),
    .prog_ready (prog_ready),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .start      (start),
    .halted     (halted),
    .lanes      (fetch_bus)
  );

  // one decoder per fetch lane
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_decode
    decode_lane u_decode (
      .fetch (fetch_bus[i]),
      .uop   (uop_bus[i])
    );
  end

  issue_execute u_exec (
    .clk           (clk),
    .rst_n         (rst_n),
    .retire_ready  (retire_ready),
    .lanes         (uop_bus),
    .retire_valid  (retire_valid),
    .retire_rd_0   (retire_rd_0),
    .retire_data_0 (retire_data_0),
    .retire_rd_1   (retire_rd_1),
    .retire_data_1 (retire_data_1),
    .halted        (halted),
    .done          (done)
  );

endmodule

// ==== src/uop_if.sv ====
`timescale 1ns/1ps

interface uop_if;
  import isa_pkg::*;
  import pipe_pkg::*;

  logic      valid;
  alu_op_e   alu_op;
  reg_addr_t rd;
  reg_addr_t rs;
  reg_addr_t rt;
  imm_t      imm;
  // second operand comes from the immediate
  logic      use_imm;
  logic      halt;
  logic      ready;

  modport source (
    output valid, alu_op, rd, rs, rt, imm, use_imm, halt,
    input  ready
  );
  modport sink (
    input  valid, alu_op, rd, rs, rt, imm, use_imm, halt,
    output ready
  );
endinterface

// ==== verification/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
  output logic clk
);

  // 8 ns period
  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

endmodule

// ==== verification/processor_tb.sv ====
`timescale 1ns/1ps

module processor_tb;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int     TIMEOUT_CYCLES = 4000;
  localparam instr_t HALT_INSTR     = 16'hF000;

  typedef struct packed {
    reg_addr_t rd;
    data_t     data;
  } retire_t;

  logic                 clk;
  logic                 rst_n;
  logic                 prog_valid;
  logic                 prog_ready;
  imem_addr_t           prog_addr;
  instr_t               prog_data;
  logic                 start;
  logic [NUM_LANES-1:0] retire_valid;
  logic                 retire_ready;
  reg_addr_t            retire_rd_0;
  data_t                retire_data_0;
  reg_addr_t            retire_rd_1;
  data_t                retire_data_1;
  logic                 done;

  instr_t  prog [IMEM_DEPTH];
  retire_t exp_q [$];
  retire_t got_q [$];
  integer  seed = 32'hf0646dc0;
  int      cycle_count = 0;

  clock_gen u_clk (.clk(clk));

  processor uut (.*);

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run("timeout: the processor never reached done");
    end
  end

  ////////////////////
  // instruction encoding
  function automatic instr_t enc_r(input opcode_e op, input int rd, input int rs, input int rt);
    return {op, rd[REG_AW-1:0], rs[REG_AW-1:0], rt[REG_AW-1:0], 3'b000};
  endfunction

  function automatic instr_t enc_i(input int rd, input int rs, input int imm);
    return {OP_ADDI, rd[REG_AW-1:0], rs[REG_AW-1:0], imm[IMM_W-1:0]};
  endfunction

  // every unused word halts
  // and carries its own address in the low bits
  task automatic clear_program();
    for (int a = 0; a < IMEM_DEPTH; a++) begin
      prog[a] = HALT_INSTR | instr_t'(a);
    end
  endtask

  ////////////////////
  // sequential reference model
  task automatic build_expected();
    data_t     rf [NUM_REGS];
    instr_t    ins;
    logic [3:0] op;
    reg_addr_t rd;
    reg_addr_t rs;
    reg_addr_t rt;
    data_t     a;
    data_t     b;
    data_t     res;
    logic      stop;
    exp_q.delete();
    stop = 1'b0;
    for (int r = 0; r < NUM_REGS; r++) begin
      rf[r] = '0;
    end
    for (int i = 0; i < IMEM_DEPTH && !stop; i++) begin
      ins = prog[i];
      op  = ins[OPCODE_MSB:OPCODE_LSB];
      rd  = ins[RD_MSB:RD_LSB];
      rs  = ins[RS_MSB:RS_LSB];
      rt  = ins[RT_MSB:RT_LSB];
      if (op > 4'd6) begin
        stop = 1'b1;
      end else begin
        a = (rs == '0) ? '0 : rf[rs];
        b = (rt == '0) ? '0 : rf[rt];
        if (op == 4'd6) b = {{(DATA_W-IMM_W){ins[IMM_MSB]}}, ins[IMM_MSB:IMM_LSB]};
        case (op)
          4'd1:    res = a - b;
          4'd2:    res = a & b;
          4'd3:    res = a | b;
          4'd4:    res = a ^ b;
          4'd5:    res = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
          default: res = a + b;
        endcase
        exp_q.push_back({rd, res});
        if (rd != '0) rf[rd] = res;
      end
    end
  endtask

  ////////////////////
  task automatic apply_reset();
    @(posedge clk);
    rst_n        <= 1'b0;
    prog_valid   <= 1'b0;
    start        <= 1'b0;
    retire_ready <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (retire_valid == '0) else
      fail_run($sformatf("[ERROR] retire_valid after reset: got 0x%h, expected 0x0",
                         retire_valid));
    assert (!done) else
      fail_run($sformatf("[ERROR] done after reset: got 0x%h, expected 0x0", done));
    assert (prog_ready) else
      fail_run($sformatf("[ERROR] prog_ready after reset: got 0x%h, expected 0x1",
                         prog_ready));
  endtask

  task automatic load_program();
    for (int a = 0; a < IMEM_DEPTH; a++) begin
      @(posedge clk);
      prog_valid <= 1'b1;
      prog_addr  <= imem_addr_t'(a);
      prog_data  <= prog[a];
      @(negedge clk);
      while (!prog_ready) @(negedge clk);
    end
    @(posedge clk);
    prog_valid <= 1'b0;
    start      <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  // scoreboard collecting lane 0 before lane 1
  task automatic collect_retires(input logic random_ready);
    int   rnd;
    logic finished;
    got_q.delete();
    finished = 1'b0;
    while (!finished) begin
      rnd = $random(seed);
      @(posedge clk);
      retire_ready <= random_ready ? rnd[0] : 1'b1;
      @(negedge clk);
      assert (retire_valid[0] || !retire_valid[1]) else
        fail_run($sformatf("[ERROR] retire_valid: got 0x%h, lane 1 without lane 0",
                           retire_valid));
      if (retire_ready && retire_valid[0]) begin
        got_q.push_back({retire_rd_0, retire_data_0});
        if (retire_valid[1]) got_q.push_back({retire_rd_1, retire_data_1});
      end
      finished = done;
    end
  endtask

  task automatic check_results();
    assert (got_q.size() == exp_q.size()) else
      fail_run($sformatf("%0d instructions retired but %0d were expected",
                         got_q.size(), exp_q.size()));
    foreach (exp_q[i]) begin
      assert (got_q[i].rd == exp_q[i].rd) else
        fail_run($sformatf("[ERROR] retire_rd at retire %0d: got 0x%h, expected 0x%h",
                           i, got_q[i].rd, exp_q[i].rd));
      assert (got_q[i].data == exp_q[i].data) else
        fail_run($sformatf("[ERROR] retire_data at retire %0d: got 0x%h, expected 0x%h",
                           i, got_q[i].data, exp_q[i].data));
    end
    // done holds and nothing retires past the halt
    repeat (4) begin
      @(negedge clk);
      assert (done && retire_valid == '0) else
        fail_run("done dropped or an instruction retired after the halt");
    end
  endtask

  task automatic run_program(input logic random_ready);
    apply_reset();
    build_expected();
    load_program();
    collect_retires(random_ready);
    check_results();
  endtask

  ////////////////////
  task automatic independent_pairs();
    clear_program();
    prog[0] = enc_i(1, 0, 5);
    prog[1] = enc_i(2, 0, 9);
    prog[2] = enc_r(OP_ADD, 3, 1, 2);
    prog[3] = enc_r(OP_SUB, 4, 1, 2);
    prog[4] = enc_r(OP_AND, 5, 1, 2);
    prog[5] = enc_r(OP_OR, 6, 1, 2);
    prog[6] = enc_r(OP_XOR, 7, 3, 4);
    prog[7] = enc_r(OP_SLT, 1, 4, 2);
    run_program(1'b0);
  endtask

  // lane 1 reads lane 0's rd in every pair
  task automatic dependent_pairs();
    clear_program();
    prog[0] = enc_i(1, 0, 7);
    prog[1] = enc_r(OP_ADD, 2, 1, 1);
    prog[2] = enc_r(OP_SUB, 3, 2, 1);
    prog[3] = enc_r(OP_XOR, 4, 2, 3);
    prog[4] = enc_i(5, 0, -3);
    prog[5] = enc_i(5, 5, 1);
    prog[6] = enc_r(OP_OR, 6, 4, 5);
    prog[7] = enc_r(OP_AND, 7, 6, 1);
    run_program(1'b0);
  endtask

  task automatic random_backpressure();
    int         rnd;
    logic [3:0] opc;
    clear_program();
    for (int i = 0; i < 24; i++) begin
      rnd = $random(seed);
      opc = {1'b0, rnd[2:0]};
      if (opc == 4'd7) opc = 4'd6;
      prog[i] = {opc, rnd[14:3]};
    end
    run_program(1'b1);
  endtask

  task automatic halt_in_lane0();
    clear_program();
    prog[0] = enc_i(1, 0, 12);
    prog[1] = enc_i(2, 0, -7);
    prog[2] = enc_r(OP_SUB, 3, 1, 2);
    prog[3] = enc_r(OP_OR, 4, 3, 1);
    prog[4] = HALT_INSTR;
    prog[5] = enc_r(OP_ADD, 5, 1, 2);
    prog[6] = enc_r(OP_ADD, 6, 1, 1);
    run_program(1'b0);
  endtask

  // opcode 9 is not defined and must stop the run
  task automatic halt_in_lane1();
    clear_program();
    prog[0] = enc_i(1, 0, 3);
    prog[1] = enc_i(2, 0, 4);
    prog[2] = enc_r(OP_ADD, 3, 1, 2);
    prog[3] = 16'h9000;
    prog[4] = enc_r(OP_ADD, 4, 1, 1);
    prog[5] = enc_r(OP_SUB, 5, 2, 1);
    run_program(1'b1);
  endtask

  // r0 is written in the first pair and read back in the next one
  task automatic operand_rules();
    clear_program();
    prog[0] = enc_i(0, 0, 5);
    prog[1] = enc_i(2, 0, -1);
    prog[2] = enc_r(OP_ADD, 1, 0, 0);
    prog[3] = enc_i(3, 0, -32);
    prog[4] = enc_r(OP_SLT, 4, 2, 3);
    prog[5] = enc_r(OP_SLT, 5, 3, 2);
    prog[6] = enc_i(6, 0, 1);
    prog[7] = enc_r(OP_SLT, 7, 2, 6);
    run_program(1'b0);
  endtask

  initial begin
    rst_n        = 1'b0;
    prog_valid   = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    start        = 1'b0;
    retire_ready = 1'b0;
    independent_pairs();
    dependent_pairs();
    random_backpressure();
    halt_in_lane0();
    halt_in_lane1();
    operand_rules();
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== vlog.f ====
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_if.sv
src/uop_if.sv
src/fetch_unit.sv
src/decode_lane.sv
src/issue_execute.sv
src/processor.sv
verification/clock_gen.sv
verification/processor_tb.sv
